// File: verilog/ps2_frame_pkg.sv
// --------------------------------------------------
// ps2 frame layout shared by the shifter and the output stage
// --------------------------------------------------

package ps2_frame_pkg;

   // one frame is start, eight data bits, parity and stop
   localparam int unsigned frame_bits_c = 11;

   // a keyboard sends this prefix ahead of the code of a released key
   localparam logic [7:0] release_code_c = 8'hF0;

   // bits arrive LSB first, so the start bit ends up at bit 0
   // once the whole frame has been shifted in at the MSB
   typedef struct packed {
      logic       stop;
      logic       parity;
      logic [7:0] data;
      logic       start;
   } ps2_frame_fields_t;

   // the shift register moves the raw word one bit at a time,
   // while the transmit load and the receive output use the fields
   typedef union packed {
      logic [frame_bits_c-1:0] raw;
      ps2_frame_fields_t       fields;
   } ps2_frame_u;

endpackage

// File: verilog/ps2_ctrl_pkg.sv
// --------------------------------------------------
// control types passed between the line FSM, timers and shifter
// --------------------------------------------------

package ps2_ctrl_pkg;

   // rx_clk_h is the idle state and is left at encoding zero
   typedef enum logic [3:0] {
      rx_clk_h,
      rx_clk_l,
      rx_fall_mark,
      rx_rise_mark,
      tx_reset_timer,
      tx_force_clk_l,
      tx_first_wait_clk_h,
      tx_wait_clk_h,
      tx_rise_mark,
      tx_clk_h,
      tx_clk_l,
      tx_wait_ack,
      tx_done_recovery,
      tx_error_no_ack
   } line_state_e;

   // enables from the FSM to the timer block
   typedef struct packed {
      logic long_en;
      logic debounce_en;
   } timer_ctrl_t;

   typedef struct packed {
      logic long_done;
      logic debounce_done;
   } timer_status_t;

   // rx_done at a full frame, tx_done once the stop bit is on the line
   typedef struct packed {
      logic rx_done;
      logic tx_done;
   } shift_status_t;

endpackage

// File: verilog/ps2_input_sync.sv
module ps2_input_sync (
   input  logic clock_i,
   input  logic ps2_clk_i,
   input  logic ps2_data_i,
   output logic clk_s_o,
   output logic data_s_o
);

   // first stage of each synchronizer, may go metastable
   logic clk_meta_q;
   logic data_meta_q;

   // the lines are open drain with slow edges, so both go through
   // two flops before the FSM looks at them
   always_ff @(posedge clock_i)
   begin
      clk_meta_q  <= ps2_clk_i;
      data_meta_q <= ps2_data_i;
      clk_s_o     <= clk_meta_q;
      data_s_o    <= data_meta_q;
   end

endmodule

// File: verilog/ps2_timers.sv
module ps2_timers import ps2_ctrl_pkg::*; #(
   parameter int unsigned long_ticks_p = 2950,
   parameter int unsigned long_bits_p  = 12
) (
   input  logic          clock_i,
   input  logic          reset_i,
   input  logic [15:0]   divide_reg_i,
   input  timer_ctrl_t   ctrl_i,
   output timer_status_t status_o
);

   logic [15:0]            presc_q;
   logic                   tick_q;
   logic [long_bits_p-1:0] long_q;
   logic                   long_done;
   logic [15:0]            deb_q;
   logic                   deb_done;

   // --------------------------------------------------
   // prescaler, one tick every divide_reg_i clocks while the long timer runs
   // --------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (reset_i || !ctrl_i.long_en)
      begin
         presc_q <= 16'd1;
         tick_q  <= 1'b0;
      end
      else if (presc_q == divide_reg_i)
      begin
         presc_q <= 16'd1;
         tick_q  <= 1'b1;
      end
      else
      begin
         presc_q <= presc_q + 16'd1;
         tick_q  <= 1'b0;
      end
   end

   // long timer counts ticks and then holds at the end value
   // it is the inhibit time on transmit and the watchdog on receive
   always_ff @(posedge clock_i)
   begin
      if (reset_i || !ctrl_i.long_en)
         long_q <= '0;
      else if (tick_q && !long_done)
         long_q <= long_q + 1'b1;
   end

   assign long_done = (long_q == long_bits_p'(long_ticks_p));

   // --------------------------------------------------
   // debounce timer, counts plain clocks and also saturates
   // --------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (reset_i || !ctrl_i.debounce_en)
         deb_q <= 16'd0;
      else if (!deb_done)
         deb_q <= deb_q + 16'd1;
   end

   assign deb_done = (deb_q == divide_reg_i - 16'd1);

   assign status_o.long_done     = long_done;
   assign status_o.debounce_done = deb_done;

endmodule

// File: verilog/ps2_line_fsm.sv
module ps2_line_fsm import ps2_ctrl_pkg::*; (
   input  logic          clock_i,
   input  logic          reset_i,
   input  logic          clk_s_i,
   input  logic          data_s_i,
   input  logic          tx_write_i,
   input  logic          tx_bit_i,
   input  timer_status_t timer_i,
   input  shift_status_t shift_i,
   output line_state_e   state_o,
   output timer_ctrl_t   timer_ctrl_o,
   output logic          ps2_clk_hi_z_o,
   output logic          ps2_data_hi_z_o,
   output logic          tx_write_ack_o,
   output logic          tx_error_no_ack_o
);

   line_state_e state_q;
   line_state_e state_d;

   always_ff @(posedge clock_i)
   begin
      if (reset_i)
         state_q <= rx_clk_h;
      else
         state_q <= state_d;
   end

   // --------------------------------------------------
   // next state and line drive
   // --------------------------------------------------
   always_comb
   begin
      // both lines released and no timer running unless a state says so
      state_d         = state_q;
      ps2_clk_hi_z_o  = 1'b1;
      ps2_data_hi_z_o = 1'b1;
      timer_ctrl_o    = '0;

      case (state_q)
         // the long timer runs as a watchdog while waiting on either clock level
         rx_clk_h:
         begin
            timer_ctrl_o.long_en = 1'b1;
            if (tx_write_i)
               state_d = tx_reset_timer;
            else if (!clk_s_i)
               state_d = rx_fall_mark;
         end
         // one cycle markers, the shifter samples data on the falling one
         rx_fall_mark:
            state_d = rx_clk_l;
         rx_rise_mark:
            state_d = rx_clk_h;
         rx_clk_l:
         begin
            timer_ctrl_o.long_en = 1'b1;
            if (tx_write_i)
               state_d = tx_reset_timer;
            else if (clk_s_i)
               state_d = rx_rise_mark;
         end
         // one cycle with the timer off so it starts the inhibit from zero
         tx_reset_timer:
            state_d = tx_force_clk_l;
         // host inhibit, the clock is held low for the long time
         tx_force_clk_l:
         begin
            timer_ctrl_o.long_en = 1'b1;
            ps2_clk_hi_z_o       = 1'b0;
            if (timer_i.long_done)
               state_d = tx_first_wait_clk_h;
         end
         // start bit driven, the keyboard now begins to clock
         tx_first_wait_clk_h:
         begin
            timer_ctrl_o.debounce_en = 1'b1;
            ps2_data_hi_z_o          = 1'b0;
            if (!clk_s_i && timer_i.debounce_done)
               state_d = tx_clk_l;
         end
         // a rising clock is only taken after the debounce time
         tx_wait_clk_h:
         begin
            timer_ctrl_o.debounce_en = 1'b1;
            ps2_data_hi_z_o          = tx_bit_i;
            if (clk_s_i && timer_i.debounce_done)
               state_d = tx_rise_mark;
         end
         // the shifter moves the next bit to its LSB here
         tx_rise_mark:
         begin
            ps2_data_hi_z_o = tx_bit_i;
            state_d         = tx_clk_h;
         end
         tx_clk_h:
         begin
            ps2_data_hi_z_o = tx_bit_i;
            if (shift_i.tx_done)
               state_d = tx_wait_ack;
            else if (!clk_s_i)
               state_d = tx_clk_l;
         end
         tx_clk_l:
         begin
            ps2_data_hi_z_o = tx_bit_i;
            if (clk_s_i)
               state_d = tx_wait_clk_h;
         end
         // data is released, the keyboard answers by pulling it low
         // while it drives the next clock low
         tx_wait_ack:
         begin
            if (!clk_s_i && data_s_i)
               state_d = tx_error_no_ack;
            else if (!clk_s_i && !data_s_i)
               state_d = tx_done_recovery;
         end
         // both endings wait for the bus to go idle again
         tx_done_recovery:
         begin
            if (clk_s_i && data_s_i)
               state_d = rx_clk_h;
         end
         tx_error_no_ack:
         begin
            if (clk_s_i && data_s_i)
               state_d = rx_clk_h;
         end
         default:
            state_d = rx_clk_h;
      endcase
   end

   // a request is only taken while the receive side is between bits,
   // and this same cycle loads the transmit frame
   assign tx_write_ack_o    = tx_write_i && ((state_q == rx_clk_h) || (state_q == rx_clk_l));
   assign tx_error_no_ack_o = (state_q == tx_error_no_ack);
   assign state_o           = state_q;

endmodule

// File: verilog/ps2_frame_shifter.sv
module ps2_frame_shifter import ps2_frame_pkg::*, ps2_ctrl_pkg::*; (
   input  logic          clock_i,
   input  logic          reset_i,
   input  logic          clk_s_i,
   input  logic          data_s_i,
   input  logic          tx_write_ack_i,
   input  logic [7:0]    tx_data_i,
   input  line_state_e   state_i,
   input  logic          long_done_i,
   output ps2_frame_u    frame_o,
   output shift_status_t shift_o
);

   logic [3:0] bit_count_q;
   logic       shift_en;
   ps2_frame_u frame_q;

   // receive samples at the falling clock, transmit advances at the rising one
   assign shift_en = (state_i == rx_fall_mark) || (state_i == tx_rise_mark);

   assign shift_o.rx_done = (bit_count_q == 4'(frame_bits_c));
   assign shift_o.tx_done = (bit_count_q == 4'(frame_bits_c - 1));

   // --------------------------------------------------
   // bit counter
   // --------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (reset_i || shift_o.rx_done || (state_i == tx_wait_ack))
         bit_count_q <= 4'd0;
      // watchdog, a frame left half done by an idle line is dropped
      else if (long_done_i && (state_i == rx_clk_h) && clk_s_i)
         bit_count_q <= 4'd0;
      else if (shift_en)
         bit_count_q <= bit_count_q + 4'd1;
   end

   // the load fills the frame with odd parity, then bits leave at the LSB
   // while the line value comes in at the MSB
   always_ff @(posedge clock_i)
   begin
      if (tx_write_ack_i)
         frame_q.fields <= '{stop: 1'b1, parity: ~^tx_data_i, data: tx_data_i, start: 1'b0};
      else if (shift_en)
         frame_q.raw <= {data_s_i, frame_q.raw[frame_bits_c-1:1]};
   end

   assign frame_o = frame_q;

endmodule

// File: verilog/ps2_rx_output.sv
module ps2_rx_output import ps2_frame_pkg::*; (
   input  logic       clock_i,
   input  logic       reset_i,
   input  logic       translate_i,
   input  logic       rx_done_i,
   input  logic       rx_read_i,
   input  ps2_frame_u frame_i,
   output logic [7:0] rx_scan_code_o,
   output logic       rx_released_o,
   output logic       rx_data_ready_o
);

   logic released;
   logic strobe;
   logic hold_released_q;

   // a release prefix is swallowed only when translation is on
   assign released = translate_i && rx_done_i && (frame_i.fields.data == release_code_c);
   assign strobe   = rx_done_i && !released;

   // remembers the prefix until the code of the key itself arrives
   always_ff @(posedge clock_i)
   begin
      if (reset_i || strobe)
         hold_released_q <= 1'b0;
      else if (released)
         hold_released_q <= 1'b1;
   end

   // --------------------------------------------------
   // output registers and ready level
   // --------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (reset_i)
      begin
         rx_scan_code_o  <= 8'd0;
         rx_released_o   <= 1'b0;
         rx_data_ready_o <= 1'b0;
      end
      else if (strobe)
      begin
         // a new code overwrites an unread one and ready just stays up
         rx_scan_code_o  <= frame_i.fields.data;
         rx_released_o   <= hold_released_q;
         rx_data_ready_o <= 1'b1;
      end
      else if (rx_read_i)
         rx_data_ready_o <= 1'b0;
   end

endmodule

// File: verilog/ps2_keyboard.sv
module ps2_keyboard import ps2_frame_pkg::*, ps2_ctrl_pkg::*; #(
   parameter int unsigned long_ticks_p = 2950,
   parameter int unsigned long_bits_p  = 12
) (
   input  logic        clock_i,
   input  logic        reset_i,
   input  logic        ps2_clk_i,
   input  logic        ps2_data_i,
   input  logic        rx_read_i,
   input  logic        tx_write_i,
   input  logic        translate_i,
   input  logic [7:0]  tx_data_i,
   input  logic [15:0] divide_reg_i,
   output logic        ps2_clk_hi_z_o,
   output logic        ps2_data_hi_z_o,
   output logic        rx_released_o,
   output logic        rx_data_ready_o,
   output logic        tx_write_ack_o,
   output logic        tx_error_no_ack_o,
   output logic [7:0]  rx_scan_code_o
);

   logic          clk_s;
   logic          data_s;
   timer_ctrl_t   timer_ctrl;
   timer_status_t timer_status;
   shift_status_t shift_status;
   line_state_e   line_state;
   ps2_frame_u    frame;

   ps2_input_sync ps2_input_sync_i (
      .clock_i    (clock_i),
      .ps2_clk_i  (ps2_clk_i),
      .ps2_data_i (ps2_data_i),
      .clk_s_o    (clk_s),
      .data_s_o   (data_s)
   );

   ps2_timers #(
      .long_ticks_p (long_ticks_p),
      .long_bits_p  (long_bits_p)
   ) ps2_timers_i (
      .clock_i      (clock_i),
      .reset_i      (reset_i),
      .divide_reg_i (divide_reg_i),
      .ctrl_i       (timer_ctrl),
      .status_o     (timer_status)
   );

   // the frame LSB is the bit currently on the data line during transmit
   ps2_line_fsm ps2_line_fsm_i (
      .clock_i           (clock_i),
      .reset_i           (reset_i),
      .clk_s_i           (clk_s),
      .data_s_i          (data_s),
      .tx_write_i        (tx_write_i),
      .tx_bit_i          (frame.raw[0]),
      .timer_i           (timer_status),
      .shift_i           (shift_status),
      .state_o           (line_state),
      .timer_ctrl_o      (timer_ctrl),
      .ps2_clk_hi_z_o    (ps2_clk_hi_z_o),
      .ps2_data_hi_z_o   (ps2_data_hi_z_o),
      .tx_write_ack_o    (tx_write_ack_o),
      .tx_error_no_ack_o (tx_error_no_ack_o)
   );

   ps2_frame_shifter ps2_frame_shifter_i (
      .clock_i        (clock_i),
      .reset_i        (reset_i),
      .clk_s_i        (clk_s),
      .data_s_i       (data_s),
      .tx_write_ack_i (tx_write_ack_o),
      .tx_data_i      (tx_data_i),
      .state_i        (line_state),
      .long_done_i    (timer_status.long_done),
      .frame_o        (frame),
      .shift_o        (shift_status)
   );

   ps2_rx_output ps2_rx_output_i (
      .clock_i         (clock_i),
      .reset_i         (reset_i),
      .translate_i     (translate_i),
      .rx_done_i       (shift_status.rx_done),
      .rx_read_i       (rx_read_i),
      .frame_i         (frame),
      .rx_scan_code_o  (rx_scan_code_o),
      .rx_released_o   (rx_released_o),
      .rx_data_ready_o (rx_data_ready_o)
   );

endmodule

// File: verif/ps2_keyboard_tb.sv
module ps2_keyboard_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int clock_period_c    = 40;
   // keyboard clock half period in system clocks
   localparam int half_bit_c        = 20;
   localparam int frame_count_c     = 8;
   localparam int watchdog_cycles_c = frame_count_c * 11 * 2 * half_bit_c + 2000;

   logic        clock_i;
   logic        reset_i;
   logic        kb_clk;
   logic        kb_data;
   logic        ps2_clk;
   logic        ps2_data;
   logic        rx_read;
   logic        tx_write;
   logic        translate;
   logic [7:0]  tx_data;
   logic [15:0] divide_reg;
   logic        clk_hi_z;
   logic        data_hi_z;
   logic        rx_released;
   logic        rx_data_ready;
   logic        tx_write_ack;
   logic        tx_error_no_ack;
   logic [7:0]  rx_scan_code;
   logic [31:0] lcg_state;
   logic        expect_ack;
   int          error_cycles = 0;

   always #(clock_period_c / 2) clock_i = ~clock_i;

   // both lines are wired-AND of the keyboard and the host
   assign ps2_clk  = kb_clk & clk_hi_z;
   assign ps2_data = kb_data & data_hi_z;

   ps2_keyboard #(
      .long_ticks_p (8),
      .long_bits_p  (4)
   ) ps2_keyboard_i (
      .clock_i           (clock_i),
      .reset_i           (reset_i),
      .ps2_clk_i         (ps2_clk),
      .ps2_data_i        (ps2_data),
      .rx_read_i         (rx_read),
      .tx_write_i        (tx_write),
      .translate_i       (translate),
      .tx_data_i         (tx_data),
      .divide_reg_i      (divide_reg),
      .ps2_clk_hi_z_o    (clk_hi_z),
      .ps2_data_hi_z_o   (data_hi_z),
      .rx_released_o     (rx_released),
      .rx_data_ready_o   (rx_data_ready),
      .tx_write_ack_o    (tx_write_ack),
      .tx_error_no_ack_o (tx_error_no_ack),
      .rx_scan_code_o    (rx_scan_code)
   );

   // counts cycles with the error output high, so a test can see it was raised
   always @(posedge clock_i)
   begin
      if (tx_error_no_ack)
         error_cycles <= error_cycles + 1;
   end

   // --------------------------------------------------
   // error reporting
   // --------------------------------------------------
   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
      stop_run();
   endtask

   task automatic report_problem(input string what);
      $display("ERROR %s", what);
      stop_run();
   endtask

   // an ack never appears unless the host side requests a write
   ack_needs_request: assert property (@(posedge clock_i) disable iff (reset_i)
      tx_write_ack |-> tx_write)
      else report_mismatch("tx_write_ack_o", 32'd0, 32'd1);

   // while the keyboard answers with an ack the error output stays low
   no_error_on_ack: assert property (@(posedge clock_i) disable iff (reset_i)
      expect_ack |-> !tx_error_no_ack)
      else report_mismatch("tx_error_no_ack_o", 32'd0, 32'd1);

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   task automatic wait_clocks(input int n);
      repeat (n) @(negedge clock_i);
   endtask

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic random_byte(output logic [7:0] b);
      lcg_state = lcg_step(lcg_state);
      b = lcg_state[23:16];
   endtask

   // start 0, data LSB first, parity that makes the ones count odd, stop 1
   function automatic logic [10:0] make_frame(input logic [7:0] b);
      return {1'b1, ~^b, b, 1'b0};
   endfunction

   // the keyboard sets data up while its clock is high and the host
   // samples it after the falling edge
   task automatic send_bits(input logic [10:0] bits, input int count);
      int i;
      for (i = 0; i < count; i++)
      begin
         kb_data = bits[i];
         wait_clocks(half_bit_c);
         kb_clk = 1'b0;
         wait_clocks(half_bit_c);
         kb_clk = 1'b1;
      end
      kb_data = 1'b1;
   endtask

   task automatic wait_ready(input int limit);
      int n;
      n = 0;
      while (!rx_data_ready && n < limit)
      begin
         @(negedge clock_i);
         n++;
      end
      assert (rx_data_ready) else report_problem("rx_data_ready_o did not rise after a frame");
   endtask

   // waits for ready, compares the code and flag, then reads it away
   task automatic check_code(input logic [7:0] code, input logic released);
      wait_ready(half_bit_c);
      assert (rx_scan_code == code) else report_mismatch("rx_scan_code_o", code, rx_scan_code);
      assert (rx_released == released)
         else report_mismatch("rx_released_o", released, rx_released);
      rx_read = 1'b1;
      @(negedge clock_i);
      rx_read = 1'b0;
      assert (rx_data_ready == 1'b0)
         else report_mismatch("rx_data_ready_o", 32'd0, rx_data_ready);
      wait_clocks(2 * half_bit_c);
   endtask

   // the request starts on a falling edge and the ack must come in the same cycle
   task automatic request_write(input logic [7:0] d);
      tx_data  = d;
      tx_write = 1'b1;
      #1;
      assert (tx_write_ack == 1'b1) else report_mismatch("tx_write_ack_o", 32'd1, tx_write_ack);
      @(negedge clock_i);
      tx_write = 1'b0;
   endtask

   // the keyboard takes host bits just before each rising edge
   // and the stop bit late in the tenth high phase
   task automatic take_command(input logic give_ack, output logic [10:0] bits);
      int n;
      int i;
      n = 0;
      while (clk_hi_z && n < 200)
      begin
         @(negedge clock_i);
         n++;
      end
      assert (!clk_hi_z) else report_problem("host never held the clock low to inhibit");
      n = 0;
      while (!clk_hi_z && n < 200)
      begin
         @(negedge clock_i);
         n++;
      end
      assert (clk_hi_z) else report_problem("host never released the clock after inhibit");
      wait_clocks(half_bit_c);
      for (i = 0; i < 10; i++)
      begin
         kb_clk = 1'b0;
         wait_clocks(half_bit_c);
         bits[i] = ps2_data;
         kb_clk = 1'b1;
         wait_clocks(half_bit_c);
      end
      bits[10] = ps2_data;
      // the acknowledge is data low during one more clock pulse
      kb_data = ~give_ack;
      wait_clocks(4);
      kb_clk = 1'b0;
      wait_clocks(half_bit_c);
      kb_clk = 1'b1;
      wait_clocks(half_bit_c);
      kb_data = 1'b1;
      wait_clocks(half_bit_c);
   endtask

   task automatic check_command(input logic [10:0] bits, input logic [7:0] d);
      assert (bits[0] == 1'b0) else report_mismatch("start bit", 32'd0, bits[0]);
      assert (bits[8:1] == d) else report_mismatch("data bits", d, bits[8:1]);
      assert (^bits[9:1] == 1'b1) else report_mismatch("odd parity of data", 32'd1, ^bits[9:1]);
      assert (bits[10] == 1'b1) else report_mismatch("stop bit", 32'd1, bits[10]);
      assert (clk_hi_z == 1'b1) else report_mismatch("ps2_clk_hi_z_o", 32'd1, clk_hi_z);
      assert (data_hi_z == 1'b1) else report_mismatch("ps2_data_hi_z_o", 32'd1, data_hi_z);
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial
   begin
      logic [7:0]  b;
      logic [10:0] bits;
      int          errors_before;
      clock_i    = 1'b0;
      reset_i    = 1'b1;
      kb_clk     = 1'b1;
      kb_data    = 1'b1;
      rx_read    = 1'b0;
      tx_write   = 1'b0;
      translate  = 1'b0;
      tx_data    = 8'd0;
      divide_reg = 16'd4;
      lcg_state  = 32'd2;
      expect_ack = 1'b0;
      repeat (2) @(negedge clock_i);
      reset_i = 1'b0;

      // reset values
      assert (rx_data_ready == 1'b0) else report_mismatch("rx_data_ready_o", 0, rx_data_ready);
      assert (rx_released == 1'b0) else report_mismatch("rx_released_o", 0, rx_released);
      assert (tx_error_no_ack == 1'b0)
         else report_mismatch("tx_error_no_ack_o", 0, tx_error_no_ack);
      assert (rx_scan_code == 8'd0) else report_mismatch("rx_scan_code_o", 0, rx_scan_code);
      assert (clk_hi_z == 1'b1) else report_mismatch("ps2_clk_hi_z_o", 1, clk_hi_z);
      assert (data_hi_z == 1'b1) else report_mismatch("ps2_data_hi_z_o", 1, data_hi_z);
      assert (tx_write_ack == 1'b0) else report_mismatch("tx_write_ack_o", 0, tx_write_ack);
      wait_clocks(half_bit_c);

      // plain receive of one random byte
      random_byte(b);
      send_bits(make_frame(b), 11);
      check_code(b, 1'b0);

      // with translation a release prefix is absorbed into the flag
      translate = 1'b1;
      random_byte(b);
      if (b == 8'hF0)
         b = 8'h1C;
      send_bits(make_frame(8'hF0), 11);
      wait_clocks(half_bit_c);
      assert (rx_data_ready == 1'b0) else report_mismatch("rx_data_ready_o", 0, rx_data_ready);
      send_bits(make_frame(b), 11);
      check_code(b, 1'b1);
      translate = 1'b0;
      send_bits(make_frame(8'hF0), 11);
      check_code(8'hF0, 1'b0);

      // command acknowledged by the keyboard
      random_byte(b);
      expect_ack = 1'b1;
      request_write(b);
      take_command(1'b1, bits);
      check_command(bits, b);
      expect_ack = 1'b0;

      // command left without an acknowledge
      random_byte(b);
      errors_before = error_cycles;
      request_write(b);
      take_command(1'b0, bits);
      check_command(bits, b);
      assert (error_cycles > errors_before)
         else report_problem("tx_error_no_ack_o never rose on a missing acknowledge");
      assert (tx_error_no_ack == 1'b0)
         else report_mismatch("tx_error_no_ack_o", 0, tx_error_no_ack);

      // a long idle after three bits makes the watchdog drop the partial frame
      random_byte(b);
      send_bits(make_frame(b), 3);
      wait_clocks(5 * half_bit_c);
      assert (rx_data_ready == 1'b0) else report_mismatch("rx_data_ready_o", 0, rx_data_ready);
      random_byte(b);
      send_bits(make_frame(b), 11);
      check_code(b, 1'b0);

      $display("PASS: all tests");
      $finish;
   end

   // run length bound from the number of frames at the keyboard bit rate
   initial
   begin
      #(watchdog_cycles_c * clock_period_c);
      report_problem("watchdog expired before the tests finished");
   end

endmodule

// File: list.f
verilog/ps2_frame_pkg.sv
verilog/ps2_ctrl_pkg.sv
verilog/ps2_input_sync.sv
verilog/ps2_timers.sv
verilog/ps2_line_fsm.sv
verilog/ps2_frame_shifter.sv
verilog/ps2_rx_output.sv
verilog/ps2_keyboard.sv
verif/ps2_keyboard_tb.sv

// File: Bender.yml
package:
  name: ps2_keyboard

sources:
  - files:
      - verilog/ps2_frame_pkg.sv
      - verilog/ps2_ctrl_pkg.sv
      - verilog/ps2_input_sync.sv
      - verilog/ps2_timers.sv
      - verilog/ps2_line_fsm.sv
      - verilog/ps2_frame_shifter.sv
      - verilog/ps2_rx_output.sv
      - verilog/ps2_keyboard.sv
  - target: test
    files:
      - verif/ps2_keyboard_tb.sv
